// ==== udp_echo_pkg.sv ====
// Shared widths, field types and the payload route encoding for the UDP echo engine.
// Modules pull these in with a wildcard import in the body and use scoped names in
// their port lists.

package udp_echo_pkg;

    // Payload stream geometry
    parameter int DATA_WIDTH = 64;
    parameter int KEEP_WIDTH = DATA_WIDTH / 8;

    // One payload beat and its byte enables
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // UDP/IP header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Board LED byte
    typedef logic [7:0] led_t;

    // Where the payload of the frame in progress goes
    typedef enum logic [1:0] {
        ROUTE_IDLE = 2'd0,
        ROUTE_ECHO = 2'd1,
        ROUTE_DROP = 2'd2
    } route_t;

endpackage

// ==== udp_port_filter.sv ====
// Destination port filter for the UDP echo engine.
// Matching headers are turned into a reply header on the fly; the route is latched at
// the header handshake and steers the payload into the FIFO or drops it until tlast.

`timescale 1ns/1ps

module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234
) (
    input  logic                      clk,
    input  logic                      rst,

    // Received UDP header
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t    rx_source_ip,
    input  udp_echo_pkg::udp_port_t   rx_source_port,
    input  udp_echo_pkg::udp_port_t   rx_dest_port,
    input  udp_echo_pkg::udp_len_t    rx_length,

    // Reply UDP header
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t    tx_dest_ip,
    output udp_echo_pkg::udp_port_t   tx_source_port,
    output udp_echo_pkg::udp_port_t   tx_dest_port,
    output udp_echo_pkg::udp_len_t    tx_length,

    // Received payload
    input  udp_echo_pkg::data_t       rx_payload_tdata,
    input  udp_echo_pkg::keep_t       rx_payload_tkeep,
    input  logic                      rx_payload_tvalid,
    output logic                      rx_payload_tready,
    input  logic                      rx_payload_tlast,
    input  logic                      rx_payload_tuser,

    // Payload FIFO write side
    output udp_echo_pkg::data_t       fifo_in_data,
    output udp_echo_pkg::keep_t       fifo_in_keep,
    output logic                      fifo_in_valid,
    input  logic                      fifo_in_ready,
    output logic                      fifo_in_last,
    output logic                      fifo_in_user
);

    import udp_echo_pkg::*;

    route_t route_q;

    logic port_match;
    logic route_idle;
    logic route_echo;
    logic route_drop;
    logic hdr_fire;
    logic beat_last_fire;

    assign port_match = (rx_dest_port == ECHO_PORT);

    assign route_idle = (route_q == ROUTE_IDLE);
    assign route_echo = (route_q == ROUTE_ECHO);
    assign route_drop = (route_q == ROUTE_DROP);

    // Header path, no register in between
    // A new header is only taken while no payload is in flight
    assign tx_hdr_valid = route_idle && rx_hdr_valid && port_match;
    assign rx_hdr_ready = route_idle && (port_match ? tx_hdr_ready : 1'b1);

    // Reply goes back to the sender with the ports swapped
    assign tx_dest_ip     = rx_source_ip;
    assign tx_source_port = rx_dest_port;
    assign tx_dest_port   = rx_source_port;
    assign tx_length      = rx_length;

    // Payload gating
    assign fifo_in_data  = rx_payload_tdata;
    assign fifo_in_keep  = rx_payload_tkeep;
    assign fifo_in_last  = rx_payload_tlast;
    assign fifo_in_user  = rx_payload_tuser;
    assign fifo_in_valid = route_echo && rx_payload_tvalid;

    // Dropped frames are drained at full rate
    assign rx_payload_tready = (route_echo && fifo_in_ready) || route_drop;

    assign hdr_fire       = rx_hdr_valid && rx_hdr_ready;
    assign beat_last_fire = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    // Route register, set per header and held until the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= ROUTE_IDLE;
        end else begin
            if (hdr_fire) begin
                route_q <= port_match ? ROUTE_ECHO : ROUTE_DROP;
            end else if (beat_last_fire) begin
                route_q <= ROUTE_IDLE;
            end
        end
    end

endmodule

// ==== udp_payload_fifo.sv ====
// Synchronous first-word-fall-through FIFO for echoed payload beats.
// Each entry carries data, keep, last and user; the head beat sits in an output
// register with a registered valid. Holds FIFO_DEPTH beats, a power of two.

`timescale 1ns/1ps

module udp_payload_fifo #(
    parameter integer FIFO_DEPTH = 512
) (
    input  logic                  clk,
    input  logic                  rst,

    // Write side
    input  udp_echo_pkg::data_t   fifo_in_data,
    input  udp_echo_pkg::keep_t   fifo_in_keep,
    input  logic                  fifo_in_valid,
    output logic                  fifo_in_ready,
    input  logic                  fifo_in_last,
    input  logic                  fifo_in_user,

    // Read side
    output udp_echo_pkg::data_t   tx_payload_tdata,
    output udp_echo_pkg::keep_t   tx_payload_tkeep,
    output logic                  tx_payload_tvalid,
    input  logic                  tx_payload_tready,
    output logic                  tx_payload_tlast,
    output logic                  tx_payload_tuser
);

    import udp_echo_pkg::*;

    localparam int ADDR_W  = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = DATA_WIDTH + KEEP_WIDTH + 2;

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] out_q;
    logic               out_valid_q;

    // One extra bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] head_next;

    logic full;
    logic push;
    logic pop;

    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign fifo_in_ready = !full;
    assign push = fifo_in_valid && !full;
    assign pop  = out_valid_q && tx_payload_tready;

    // rd_ptr points at the beat shown on the output
    assign head_next = rd_ptr + {{ADDR_W{1'b0}}, pop};

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {fifo_in_user, fifo_in_last, fifo_in_keep, fifo_in_data};
        end
        // Head reload, a beat written this edge shows up one edge later
        out_q <= mem[head_next[ADDR_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr      <= head_next;
            out_valid_q <= (head_next != wr_ptr);
        end
    end

    assign {tx_payload_tuser, tx_payload_tlast, tx_payload_tkeep, tx_payload_tdata} = out_q;
    assign tx_payload_tvalid = out_valid_q;

endmodule

// ==== udp_echo_top.sv ====
// Top level of the UDP echo engine, placed between the receive and transmit sides
// of a UDP/IP stack. Frames to ECHO_PORT come back to their sender through the
// payload FIFO; led shows the low byte of the first beat of each outgoing burst.

`timescale 1ns/1ps

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT  = 16'd1234,
    parameter integer                  FIFO_DEPTH = 512
) (
    input  logic                      clk,
    input  logic                      rst,

    // Received UDP header
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t    rx_source_ip,
    input  udp_echo_pkg::udp_port_t   rx_source_port,
    input  udp_echo_pkg::udp_port_t   rx_dest_port,
    input  udp_echo_pkg::udp_len_t    rx_length,

    // Received payload
    input  udp_echo_pkg::data_t       rx_payload_tdata,
    input  udp_echo_pkg::keep_t       rx_payload_tkeep,
    input  logic                      rx_payload_tvalid,
    output logic                      rx_payload_tready,
    input  logic                      rx_payload_tlast,
    input  logic                      rx_payload_tuser,

    // Reply UDP header
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t    tx_dest_ip,
    output udp_echo_pkg::udp_port_t   tx_source_port,
    output udp_echo_pkg::udp_port_t   tx_dest_port,
    output udp_echo_pkg::udp_len_t    tx_length,

    // Reply payload
    output udp_echo_pkg::data_t       tx_payload_tdata,
    output udp_echo_pkg::keep_t       tx_payload_tkeep,
    output logic                      tx_payload_tvalid,
    input  logic                      tx_payload_tready,
    output logic                      tx_payload_tlast,
    output logic                      tx_payload_tuser,

    output udp_echo_pkg::led_t        led
);

    import udp_echo_pkg::*;

    // Filter to FIFO
    data_t fifo_in_data;
    keep_t fifo_in_keep;
    logic  fifo_in_valid;
    logic  fifo_in_ready;
    logic  fifo_in_last;
    logic  fifo_in_user;

    logic  tx_valid_q;
    led_t  led_q;

    udp_port_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) u_port_filter (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_source_ip      (rx_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_dest_ip        (tx_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .fifo_in_data      (fifo_in_data),
        .fifo_in_keep      (fifo_in_keep),
        .fifo_in_valid     (fifo_in_valid),
        .fifo_in_ready     (fifo_in_ready),
        .fifo_in_last      (fifo_in_last),
        .fifo_in_user      (fifo_in_user)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_payload_fifo (
        .clk               (clk),
        .rst               (rst),
        .fifo_in_data      (fifo_in_data),
        .fifo_in_keep      (fifo_in_keep),
        .fifo_in_valid     (fifo_in_valid),
        .fifo_in_ready     (fifo_in_ready),
        .fifo_in_last      (fifo_in_last),
        .fifo_in_user      (fifo_in_user),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser)
    );

    // First byte of each burst onto the LEDs, caught on the rise of tvalid
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid_q <= 1'b0;
            led_q      <= '0;
        end else begin
            tx_valid_q <= tx_payload_tvalid;
            if (tx_payload_tvalid && !tx_valid_q) begin
                led_q <= tx_payload_tdata[7:0];
            end
        end
    end

    assign led = led_q;

endmodule

// ==== tb_udp_echo.sv ====
// Self-checking testbench for the UDP echo engine.
// Random frames from an LCG go into the receive side; a model of queued reply
// headers and payload beats is compared with what leaves the transmit side.

`timescale 1ns/1ps

module tb_udp_echo;

    import udp_echo_pkg::*;

    localparam udp_port_t ECHO_PORT  = 16'd1234;
    localparam int        FIFO_DEPTH = 16;
    localparam int        WAIT_LIMIT = 2000;

    typedef struct packed {
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } reply_hdr_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } beat_t;

    logic      clk;
    logic      rst;
    logic      rx_hdr_valid;
    logic      rx_hdr_ready;
    ip_addr_t  rx_source_ip;
    udp_port_t rx_source_port;
    udp_port_t rx_dest_port;
    udp_len_t  rx_length;
    data_t     rx_payload_tdata;
    keep_t     rx_payload_tkeep;
    logic      rx_payload_tvalid;
    logic      rx_payload_tready;
    logic      rx_payload_tlast;
    logic      rx_payload_tuser;
    logic      tx_hdr_valid;
    logic      tx_hdr_ready;
    ip_addr_t  tx_dest_ip;
    udp_port_t tx_source_port;
    udp_port_t tx_dest_port;
    udp_len_t  tx_length;
    data_t     tx_payload_tdata;
    keep_t     tx_payload_tkeep;
    logic      tx_payload_tvalid;
    logic      tx_payload_tready;
    logic      tx_payload_tlast;
    logic      tx_payload_tuser;
    led_t      led;

    // Model state
    reply_hdr_t  hdr_q [$];
    beat_t       beat_q [$];
    logic [31:0] seed = 32'h95f0;
    logic        random_ready;

    // Cycles where a receive payload beat waited on a full FIFO
    int          rx_stalls = 0;

    udp_echo_top #(
        .ECHO_PORT(ECHO_PORT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk(clk), .rst(rst),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_source_ip(rx_source_ip), .rx_source_port(rx_source_port),
        .rx_dest_port(rx_dest_port), .rx_length(rx_length),
        .rx_payload_tdata(rx_payload_tdata), .rx_payload_tkeep(rx_payload_tkeep),
        .rx_payload_tvalid(rx_payload_tvalid), .rx_payload_tready(rx_payload_tready),
        .rx_payload_tlast(rx_payload_tlast), .rx_payload_tuser(rx_payload_tuser),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_dest_ip(tx_dest_ip), .tx_source_port(tx_source_port),
        .tx_dest_port(tx_dest_port), .tx_length(tx_length),
        .tx_payload_tdata(tx_payload_tdata), .tx_payload_tkeep(tx_payload_tkeep),
        .tx_payload_tvalid(tx_payload_tvalid), .tx_payload_tready(tx_payload_tready),
        .tx_payload_tlast(tx_payload_tlast), .tx_payload_tuser(tx_payload_tuser),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_header(input string name, input reply_hdr_t exp,
                                input ip_addr_t ip, input udp_port_t src_port,
                                input udp_port_t dst_port, input udp_len_t len);
        if (ip !== exp.dest_ip) begin
            stop_with_error($sformatf("ERR %s dest_ip: expected %h, actual %h",
                                      name, exp.dest_ip, ip));
        end
        if (src_port !== exp.source_port) begin
            stop_with_error($sformatf("ERR %s source_port: expected %h, actual %h",
                                      name, exp.source_port, src_port));
        end
        if (dst_port !== exp.dest_port) begin
            stop_with_error($sformatf("ERR %s dest_port: expected %h, actual %h",
                                      name, exp.dest_port, dst_port));
        end
        if (len !== exp.length) begin
            stop_with_error($sformatf("ERR %s length: expected %h, actual %h",
                                      name, exp.length, len));
        end
    endtask

    task automatic check_beat(input string name, input beat_t exp, input data_t data,
                              input keep_t keep, input logic last, input logic user);
        if ({data, keep, last, user} !== exp) begin
            stop_with_error($sformatf("ERR %s: expected %h/%h/%b/%b, actual %h/%h/%b/%b",
                                      name, exp.data, exp.keep, exp.last, exp.user,
                                      data, keep, last, user));
        end
    endtask

    task automatic check_led(input string name, input led_t exp, input led_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Advance to the next falling edge and redraw the ready inputs when enabled
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        if (random_ready) begin
            r = next_random();
            tx_payload_tready = (r[31:24] < 8'd154);
            tx_hdr_ready      = (r[23:16] < 8'd192);
        end
    endtask

    // Sends one frame and loads the model with what should come back
    task automatic send_frame(input bit force_echo, output bit echoed, output led_t first_byte);
        logic [31:0] r;
        int          beats;
        int          tries;
        bit          fire;
        beat_t       frame [$];
        beat_t       b;
        r = next_random();
        rx_source_ip = next_random();
        rx_source_port = r[15:0];
        rx_length = r[31:16];
        r = next_random();
        rx_dest_port = r[30:15];
        if (force_echo || r[31]) begin
            rx_dest_port = ECHO_PORT;
        end else if (rx_dest_port == ECHO_PORT) begin
            rx_dest_port = rx_dest_port ^ 16'd1;
        end
        echoed = (rx_dest_port == ECHO_PORT);
        r = next_random();
        beats = 1 + int'(r[31:16] % 16'd12);
        for (int i = 0; i < beats; i++) begin
            b.data = {next_random(), next_random()};
            r = next_random();
            b.keep = r[31:24];
            b.user = r[23];
            b.last = (i == beats - 1);
            frame.push_back(b);
        end
        first_byte = frame[0].data[7:0];
        if (echoed) begin
            hdr_q.push_back({rx_source_ip, rx_dest_port, rx_source_port, rx_length});
            foreach (frame[i]) begin
                beat_q.push_back(frame[i]);
            end
        end

        // Header handshake completes when ready is seen high before the rising edge
        rx_hdr_valid = 1'b1;
        tries = 0;
        fire = 1'b0;
        while (!fire) begin
            #1;
            check_flag("reply header valid", echoed, tx_hdr_valid);
            fire = rx_hdr_ready;
            if (!echoed) begin
                check_flag("dropped header ready", 1'b1, fire);
            end
            next_cycle();
            tries++;
            if (!fire && tries > WAIT_LIMIT) begin
                stop_with_error("Timeout waiting for the receive header to be accepted");
            end
        end
        rx_hdr_valid = 1'b0;

        foreach (frame[i]) begin
            rx_payload_tvalid = 1'b1;
            {rx_payload_tdata, rx_payload_tkeep, rx_payload_tlast, rx_payload_tuser} = frame[i];
            tries = 0;
            fire = 1'b0;
            while (!fire) begin
                #1;
                fire = rx_payload_tready;
                if (!echoed) begin
                    check_flag("dropped payload ready", 1'b1, fire);
                end
                next_cycle();
                tries++;
                if (!fire && tries > WAIT_LIMIT) begin
                    stop_with_error("Timeout waiting for a receive payload beat to be accepted");
                end
            end
        end
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
    endtask

    task automatic wait_drained();
        int tries;
        tries = 0;
        while (beat_q.size() != 0 || tx_payload_tvalid) begin
            next_cycle();
            tries++;
            if (tries > WAIT_LIMIT) begin
                stop_with_error("Timeout waiting for the echoed payload to drain");
            end
        end
    endtask

    // Transmit side monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (tx_hdr_valid) begin
                if (hdr_q.size() == 0) begin
                    stop_with_error("Transmit header appeared with no matching receive header");
                end else begin
                    check_header("reply header", hdr_q[0], tx_dest_ip, tx_source_port,
                                 tx_dest_port, tx_length);
                    if (tx_hdr_ready) begin
                        void'(hdr_q.pop_front());
                    end
                end
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                if (beat_q.size() == 0) begin
                    stop_with_error("Transmit payload beat appeared with none expected");
                end else begin
                    check_beat("payload beat", beat_q.pop_front(), tx_payload_tdata,
                               tx_payload_tkeep, tx_payload_tlast, tx_payload_tuser);
                end
            end
            if (rx_payload_tvalid && !rx_payload_tready) begin
                rx_stalls++;
            end
        end
    end

    initial begin
        bit   echoed;
        led_t first_byte;
        led_t exp_led;
        int   tries;
        rst = 1'b1;
        random_ready = 1'b0;
        rx_hdr_valid = 1'b0;
        rx_source_ip = '0;
        rx_source_port = '0;
        rx_dest_port = '0;
        rx_length = '0;
        rx_payload_tdata = '0;
        rx_payload_tkeep = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast = 1'b0;
        rx_payload_tuser = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_payload_tready = 1'b0;
        exp_led = '0;

        // Reset state during and just after reset
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_flag("reset tx_hdr_valid", 1'b0, tx_hdr_valid);
                check_flag("reset tx_payload_tvalid", 1'b0, tx_payload_tvalid);
                check_led("reset led", 8'h00, led);
            end
        end
        rst = 1'b0;
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            check_flag("after reset tx_hdr_valid", 1'b0, tx_hdr_valid);
            check_flag("after reset tx_payload_tvalid", 1'b0, tx_payload_tvalid);
            check_led("after reset led", 8'h00, led);
        end

        // Stalled transmit side fills the FIFO until the receive payload backs up
        tx_hdr_ready = 1'b1;
        fork
            begin
                while (rx_stalls == 0) begin
                    send_frame(1'b1, echoed, first_byte);
                end
            end
            begin
                tries = 0;
                while (rx_stalls == 0) begin
                    @(negedge clk);
                    tries++;
                    if (rx_stalls == 0 && tries > WAIT_LIMIT) begin
                        stop_with_error("Timeout waiting for the payload FIFO to fill");
                    end
                end
                tx_payload_tready = 1'b1;
            end
        join
        wait_drained();

        // Back-to-back frames under random back-pressure
        random_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_frame(1'b0, echoed, first_byte);
        end
        random_ready = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_payload_tready = 1'b1;
        wait_drained();

        // One frame at a time so the LED shows each frame's first byte
        for (int i = 0; i < 12; i++) begin
            send_frame(i == 0, echoed, first_byte);
            wait_drained();
            if (echoed) begin
                exp_led = first_byte;
            end
            check_led("led first byte", exp_led, led);
        end

        if (hdr_q.size() != 0 || beat_q.size() != 0) begin
            stop_with_error("Expected reply headers or beats never left the DUT");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
udp_echo_pkg.sv
udp_port_filter.sv
udp_payload_fifo.sv
udp_echo_top.sv
tb_udp_echo.sv

// ==== Makefile ====
# Verilator build and run for the UDP echo engine testbench.
# Any variable can be overridden on the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A $$fatal in the testbench gives a non-zero exit status, which fails this target
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
